/* src/core_pkg.sv */
package core_pkg;

    // on-chip ROM, replaces the SDRAM of the full core
    localparam int ROM_AW = 8;

    // default video geometry, counted in pixels and lines
    localparam int H_ACTIVE = 32;
    localparam int H_TOTAL  = 40;
    localparam int V_ACTIVE = 24;
    localparam int V_TOTAL  = 28;

    // clk27 cycles per pixel
    localparam int CEN_DIV = 2;

    // width of each colour channel
    localparam int COLOR_W = 4;

endpackage

/* src/spi_byte_rx.sv */
`timescale 1ns/1ps

module spi_byte_rx (
    input  logic       clk27,
    input  logic       rst,
    input  logic       spi_sck,
    input  logic       spi_ss2,
    input  logic       spi_di,
    output logic [7:0] rx_byte,
    output logic       rx_strobe,
    output logic       rx_active
);

    logic [1:0] sck_sync;
    logic [1:0] ss2_sync;
    logic [1:0] di_sync;
    logic       sck_last;
    logic       sck_rise;
    logic [6:0] shift;
    logic [2:0] bit_cnt;

    // two-flop synchronisers, SS2 idles high
    always_ff @(posedge clk27) begin
        if (rst) begin
            sck_sync <= 2'b00;
            ss2_sync <= 2'b11;
            di_sync  <= 2'b00;
            sck_last <= 1'b0;
        end else begin
            sck_sync <= {sck_sync[0], spi_sck};
            ss2_sync <= {ss2_sync[0], spi_ss2};
            di_sync  <= {di_sync[0], spi_di};
            sck_last <= sck_sync[1];
        end
    end

    assign sck_rise  = sck_sync[1] & ~sck_last;
    assign rx_active = ~ss2_sync[1];

    // bit counter wraps after the 8th edge
    always_ff @(posedge clk27) begin
        if (rst) begin
            bit_cnt   <= 3'd0;
            shift     <= 7'd0;
            rx_strobe <= 1'b0;
        end else begin
            rx_strobe <= 1'b0;
            if (ss2_sync[1]) begin
                bit_cnt <= 3'd0;
                shift   <= 7'd0;
            end else if (sck_rise) begin
                shift   <= {shift[5:0], di_sync[1]};
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    rx_strobe <= 1'b1;
                end
            end
        end
    end

    // MSB first, last bit joins the seven already shifted in
    always_ff @(posedge clk27) begin
        if (sck_rise && bit_cnt == 3'd7) begin
            rx_byte <= {shift, di_sync[1]};
        end
    end

endmodule

/* src/ioctl_loader.sv */
`timescale 1ns/1ps

module ioctl_loader (
    input  logic                        clk27,
    input  logic                        rst,
    input  logic [7:0]                  rx_byte,
    input  logic                        rx_strobe,
    input  logic                        rx_active,
    output logic [core_pkg::ROM_AW-1:0] ioctl_addr,
    output logic [7:0]                  ioctl_dout,
    output logic                        ioctl_wr,
    output logic                        downloading,
    output logic                        led
);

    logic [core_pkg::ROM_AW-1:0] addr;
    logic                        dl_start;

    // downloading is rx_active one cycle late, so this marks the SS2 fall
    assign dl_start = rx_active & ~downloading;

    always_ff @(posedge clk27) begin
        if (rst) begin
            addr        <= '0;
            ioctl_wr    <= 1'b0;
            downloading <= 1'b0;
            led         <= 1'b1;
        end else begin
            downloading <= rx_active;
            // LED goes dark while the ROM is loading
            led         <= ~downloading;
            ioctl_wr    <= rx_strobe;
            if (dl_start) begin
                addr <= '0;
            end else if (rx_strobe) begin
                addr <= addr + 1'b1;
            end
        end
    end

    // byte and address captured together for the write pulse
    always_ff @(posedge clk27) begin
        if (rx_strobe) begin
            ioctl_addr <= addr;
            ioctl_dout <= rx_byte;
        end
    end

endmodule

/* src/vid_timing.sv */
`timescale 1ns/1ps

module vid_timing #(
    parameter int H_ACTIVE = core_pkg::H_ACTIVE,
    parameter int H_TOTAL  = core_pkg::H_TOTAL,
    parameter int V_ACTIVE = core_pkg::V_ACTIVE,
    parameter int V_TOTAL  = core_pkg::V_TOTAL,
    parameter int CEN_DIV  = core_pkg::CEN_DIV
) (
    input  logic                       clk27,
    input  logic                       rst,
    output logic                       pxl_cen,
    output logic [$clog2(H_TOTAL)-1:0] h_cnt,
    output logic [$clog2(V_TOTAL)-1:0] v_cnt,
    output logic                       hb,
    output logic                       vb
);

    localparam int HW    = $clog2(H_TOTAL);
    localparam int VW    = $clog2(V_TOTAL);
    localparam int DIV_W = (CEN_DIV > 1) ? $clog2(CEN_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;

    // pixel enable, one pulse every CEN_DIV cycles
    always_ff @(posedge clk27) begin
        if (rst) begin
            div_cnt <= '0;
            pxl_cen <= 1'b0;
        end else if (div_cnt == DIV_W'(CEN_DIV - 1)) begin
            div_cnt <= '0;
            pxl_cen <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            pxl_cen <= 1'b0;
        end
    end

    // line counter inside frame counter
    always_ff @(posedge clk27) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (pxl_cen) begin
            if (h_cnt == HW'(H_TOTAL - 1)) begin
                h_cnt <= '0;
                if (v_cnt == VW'(V_TOTAL - 1)) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // blanking covers everything past the active area
    assign hb = int'(h_cnt) >= H_ACTIVE;
    assign vb = int'(v_cnt) >= V_ACTIVE;

endmodule

/* src/tile_render.sv */
`timescale 1ns/1ps

module tile_render (
    input  logic                         clk27,
    input  logic                         rst,
    input  logic [core_pkg::ROM_AW-1:0]  ioctl_addr,
    input  logic [7:0]                   ioctl_dout,
    input  logic                         ioctl_wr,
    input  logic                         downloading,
    input  logic                         pxl_cen,
    input  logic [3:0]                   h_cnt,
    input  logic [3:0]                   v_cnt,
    input  logic                         hb,
    input  logic                         vb,
    output logic [core_pkg::COLOR_W-1:0] red,
    output logic [core_pkg::COLOR_W-1:0] green,
    output logic [core_pkg::COLOR_W-1:0] blue,
    output logic                         pxl_hb,
    output logic                         pxl_vb
);

    localparam int AW = core_pkg::ROM_AW;
    localparam int CW = core_pkg::COLOR_W;

    logic [7:0]    rom [0:(2**AW)-1];
    logic [AW-1:0] rd_addr;
    logic [7:0]    rd_q;
    logic          blank_q;

    always_ff @(posedge clk27) begin
        if (ioctl_wr) begin
            rom[ioctl_addr] <= ioctl_dout;
        end
    end

    // 16x16 tile repeated over the screen
    assign rd_addr = AW'({v_cnt, h_cnt});

    always_ff @(posedge clk27) begin
        if (pxl_cen) begin
            rd_q <= rom[rd_addr];
        end
    end

    // blanking delayed by one pixel to line up with rd_q
    always_ff @(posedge clk27) begin
        if (rst) begin
            blank_q <= 1'b1;
            pxl_hb  <= 1'b0;
            pxl_vb  <= 1'b0;
        end else if (pxl_cen) begin
            blank_q <= hb | vb;
            pxl_hb  <= hb;
            pxl_vb  <= vb;
        end
    end

    // high nibble is red, low nibble green, blue mixes both
    assign red   = (blank_q | downloading) ? '0 : rd_q[7 -: CW];
    assign green = (blank_q | downloading) ? '0 : rd_q[CW-1:0];
    assign blue  = red ^ green;

endmodule

/* src/core_top.sv */
`timescale 1ns/1ps

module core_top #(
    parameter int H_ACTIVE = core_pkg::H_ACTIVE,
    parameter int H_TOTAL  = core_pkg::H_TOTAL,
    parameter int V_ACTIVE = core_pkg::V_ACTIVE,
    parameter int V_TOTAL  = core_pkg::V_TOTAL,
    parameter int CEN_DIV  = core_pkg::CEN_DIV
) (
    input  logic                         clk27,
    input  logic                         rst,
    input  logic                         spi_sck,
    input  logic                         spi_ss2,
    input  logic                         spi_di,
    output logic                         led,
    output logic                         pxl_cen,
    output logic                         pxl_hb,
    output logic                         pxl_vb,
    output logic [core_pkg::COLOR_W-1:0] red,
    output logic [core_pkg::COLOR_W-1:0] green,
    output logic [core_pkg::COLOR_W-1:0] blue,
    output logic [31:0]                  frame_cnt
);

    localparam int HW = $clog2(H_TOTAL);
    localparam int VW = $clog2(V_TOTAL);

    logic [7:0]                  rx_byte;
    logic                        rx_strobe;
    logic                        rx_active;
    logic [core_pkg::ROM_AW-1:0] ioctl_addr;
    logic [7:0]                  ioctl_dout;
    logic                        ioctl_wr;
    logic                        downloading;
    logic [HW-1:0]               h_cnt;
    logic [VW-1:0]               v_cnt;
    logic [3:0]                  h_tile;
    logic [3:0]                  v_tile;
    logic                        hb;
    logic                        vb;
    logic                        vb_last;

    // download path
    spi_byte_rx u_rx (
        .clk27      ( clk27      ),
        .rst        ( rst        ),
        .spi_sck    ( spi_sck    ),
        .spi_ss2    ( spi_ss2    ),
        .spi_di     ( spi_di     ),
        .rx_byte    ( rx_byte    ),
        .rx_strobe  ( rx_strobe  ),
        .rx_active  ( rx_active  )
    );

    ioctl_loader u_loader (
        .clk27       ( clk27       ),
        .rst         ( rst         ),
        .rx_byte     ( rx_byte     ),
        .rx_strobe   ( rx_strobe   ),
        .rx_active   ( rx_active   ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .downloading ( downloading ),
        .led         ( led         )
    );

    // video path
    vid_timing #(
        .H_ACTIVE ( H_ACTIVE ),
        .H_TOTAL  ( H_TOTAL  ),
        .V_ACTIVE ( V_ACTIVE ),
        .V_TOTAL  ( V_TOTAL  ),
        .CEN_DIV  ( CEN_DIV  )
    ) u_timing (
        .clk27    ( clk27    ),
        .rst      ( rst      ),
        .pxl_cen  ( pxl_cen  ),
        .h_cnt    ( h_cnt    ),
        .v_cnt    ( v_cnt    ),
        .hb       ( hb       ),
        .vb       ( vb       )
    );

    // only the position inside the tile reaches the renderer
    assign h_tile = 4'(h_cnt);
    assign v_tile = 4'(v_cnt);

    tile_render u_render (
        .clk27       ( clk27       ),
        .rst         ( rst         ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .downloading ( downloading ),
        .pxl_cen     ( pxl_cen     ),
        .h_cnt       ( h_tile      ),
        .v_cnt       ( v_tile      ),
        .hb          ( hb          ),
        .vb          ( vb          ),
        .red         ( red         ),
        .green       ( green       ),
        .blue        ( blue        ),
        .pxl_hb      ( pxl_hb      ),
        .pxl_vb      ( pxl_vb      )
    );

    // frame counter, one step per vertical blank start
    always_ff @(posedge clk27) begin
        if (rst) begin
            vb_last   <= 1'b0;
            frame_cnt <= 32'd0;
        end else begin
            vb_last <= pxl_vb;
            if (pxl_vb && !vb_last) begin
                frame_cnt <= frame_cnt + 32'd1;
            end
        end
    end

endmodule

/* tests/core_test.sv */
`timescale 1ns/1ps

module core_test;

    localparam int ROM_N     = 2 ** core_pkg::ROM_AW;
    localparam int N_PX      = 6;
    localparam int CW        = core_pkg::COLOR_W;
    localparam int H_BL      = core_pkg::H_TOTAL - core_pkg::H_ACTIVE;
    localparam int V_BL      = core_pkg::V_TOTAL - core_pkg::V_ACTIVE;
    localparam int FRAME_CYC = core_pkg::H_TOTAL * core_pkg::V_TOTAL * core_pkg::CEN_DIV;

    logic          clk27 = 1'b0;
    logic          rst;
    logic          spi_sck;
    logic          spi_ss2;
    logic          spi_di;
    logic          led;
    logic          pxl_cen;
    logic          pxl_hb;
    logic          pxl_vb;
    logic [CW-1:0] red;
    logic [CW-1:0] green;
    logic [CW-1:0] blue;
    logic [31:0]   frame_cnt;

    // ROM image followed by h v red green blue for each checked pixel
    logic [7:0] gold [0:ROM_N+5*N_PX-1];

    int            errors = 0;
    int            tests = 0;
    int            h_pos = 0;
    int            v_pos = 0;
    int            hb_run = 0;
    int            vb_lines = 0;
    int            vb_rises = 0;
    int            lines_seen = 0;
    int            cen_gap = 0;
    logic          cen_seen = 1'b0;
    logic          synced = 1'b0;
    logic          hb_q = 1'b0;
    logic          vb_q = 1'b0;
    logic          px_en = 1'b0;
    logic          dl_chk = 1'b0;
    logic [N_PX-1:0] px_hit = '0;

    core_top dut0 (
        .clk27     ( clk27     ),
        .rst       ( rst       ),
        .spi_sck   ( spi_sck   ),
        .spi_ss2   ( spi_ss2   ),
        .spi_di    ( spi_di    ),
        .led       ( led       ),
        .pxl_cen   ( pxl_cen   ),
        .pxl_hb    ( pxl_hb    ),
        .pxl_vb    ( pxl_vb    ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      ),
        .frame_cnt ( frame_cnt )
    );

    always #10 clk27 = ~clk27;

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s = %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - err_before);
        end
    endtask

    // golden lookup for one active pixel
    task automatic check_pixel(input int ph, input int pv);
        int         k;
        int         base;
        logic [7:0] b;
        for (k = 0; k < N_PX; k++) begin
            base = ROM_N + 5 * k;
            if (int'(gold[base]) == ph && int'(gold[base+1]) == pv) begin
                b = gold[(pv % 16) * 16 + (ph % 16)];
                if (gold[base+2] != 8'(b[7:4]) || gold[base+3] != 8'(b[3:0])
                        || gold[base+4] != 8'(b[7:4] ^ b[3:0])) begin
                    $display("golden entry %0d does not follow the colour rule", k);
                    errors++;
                end
                compare("red", 32'(red), 32'(gold[base+2]));
                compare("green", 32'(green), 32'(gold[base+3]));
                compare("blue", 32'(blue), 32'(gold[base+4]));
                px_hit[k] = 1'b1;
            end
        end
    endtask

    // own pixel position rebuilt from the blanking outputs
    always @(negedge clk27) begin
        if (!rst) begin
            if ((pxl_hb || pxl_vb || dl_chk) && {red, green, blue} != '0) begin
                $display("Mismatch at %0t: colour = %0h, expected 0", $time, {red, green, blue});
                errors++;
            end
            if (dl_chk) begin
                compare("led", 32'(led), 32'd0);
            end
            cen_gap++;
            if (pxl_cen) begin
                // pixel enable spacing in clk27 cycles
                if (cen_seen) begin
                    compare("pxl_cen period", cen_gap, core_pkg::CEN_DIV);
                end
                cen_seen = 1'b1;
                cen_gap = 0;
                if (hb_q && !pxl_hb) begin
                    if (synced) begin
                        compare("hblank pixels", hb_run, H_BL);
                        lines_seen++;
                    end
                    hb_run = 0;
                    h_pos = 0;
                    v_pos++;
                    if (pxl_vb) begin
                        vb_lines++;
                    end
                end else begin
                    h_pos++;
                end
                if (vb_q && !pxl_vb) begin
                    if (synced) begin
                        compare("vblank lines", vb_lines, V_BL);
                    end
                    synced = 1'b1;
                    v_pos = 0;
                    vb_lines = 0;
                end
                if (pxl_hb) begin
                    hb_run++;
                end
                if (pxl_vb && !vb_q) begin
                    vb_rises++;
                end
                if (px_en && synced && !pxl_hb && !pxl_vb) begin
                    check_pixel(h_pos, v_pos);
                end
                hb_q = pxl_hb;
                vb_q = pxl_vb;
            end
        end
    end

    task automatic spi_send(input logic [7:0] data);
        int i;
        for (i = 7; i >= 0; i--) begin
            spi_sck <= 1'b0;
            spi_di  <= data[i];
            repeat (4) @(posedge clk27);
            spi_sck <= 1'b1;
            repeat (4) @(posedge clk27);
        end
    endtask

    task automatic spi_download(input int n_bytes);
        int i;
        @(posedge clk27);
        spi_ss2 <= 1'b0;
        repeat (4) @(posedge clk27);
        for (i = 0; i < n_bytes; i++) begin
            spi_send(gold[i]);
            // led is dark by now and stays dark to the end
            dl_chk = 1'b1;
        end
        dl_chk = 1'b0;
        spi_sck <= 1'b0;
        repeat (4) @(posedge clk27);
        spi_ss2 <= 1'b1;
    endtask

    task automatic wait_led(input logic level, input int limit, output logic ok);
        int n;
        n = 0;
        @(negedge clk27);
        while (led !== level && n < limit) begin
            @(negedge clk27);
            n++;
        end
        ok = (led === level);
    endtask

    task automatic wait_frames(input int n, output logic ok);
        int start;
        int cycles;
        @(posedge clk27);
        start = vb_rises;
        cycles = 0;
        while (vb_rises - start < n && cycles < n * FRAME_CYC * 2) begin
            @(posedge clk27);
            cycles++;
        end
        ok = (vb_rises - start >= n);
    endtask

    initial begin
        int   err0;
        int   fc0;
        int   r0;
        int   k;
        int   n;
        int   l0;
        logic ok;
        $readmemh("tests/core_golden.txt", gold);
        rst = 1'b1;
        spi_sck = 1'b0;
        spi_ss2 = 1'b1;
        spi_di = 1'b0;
        repeat (3) @(posedge clk27);
        rst <= 1'b0;

        err0 = errors;
        @(negedge clk27);
        compare("led", 32'(led), 32'd1);
        compare("frame_cnt", frame_cnt, 32'd0);
        compare("colour", 32'({red, green, blue}), 32'd0);
        compare("pxl_cen", 32'(pxl_cen), 32'd0);
        report_test("reset values", err0);

        err0 = errors;
        spi_download(ROM_N);
        wait_led(1'b1, 50, ok);
        if (!ok) begin
            $display("led did not return high after the download");
            errors++;
        end
        report_test("ROM download", err0);

        err0 = errors;
        px_en = 1'b1;
        n = 0;
        while (!(&px_hit) && n < 3 * FRAME_CYC) begin
            @(posedge clk27);
            n++;
        end
        px_en = 1'b0;
        if (!(&px_hit)) begin
            $display("not every golden pixel position was reached");
            errors++;
        end
        report_test("golden pixels", err0);

        err0 = errors;
        l0 = lines_seen;
        wait_frames(2, ok);
        if (!ok || lines_seen - l0 < core_pkg::V_TOTAL) begin
            $display("video frames did not arrive in time");
            errors++;
        end
        report_test("blanking widths", err0);

        err0 = errors;
        wait_frames(1, ok);
        @(negedge clk27);
        fc0 = int'(frame_cnt);
        r0 = vb_rises;
        k = 0;
        n = 0;
        while (ok && k < 3 && n < 4 * FRAME_CYC) begin
            @(posedge clk27);
            n++;
            if (vb_rises - r0 > k) begin
                k++;
                @(negedge clk27);
                compare("frame_cnt", frame_cnt, 32'(fc0 + k));
            end
        end
        if (k < 3) begin
            $display("three vertical blanks were not seen in time");
            errors++;
        end
        report_test("frame counter", err0);

        err0 = errors;
        spi_download(8);
        wait_led(1'b1, 50, ok);
        if (!ok) begin
            $display("led did not return high after the short download");
            errors++;
        end
        report_test("colours dark while loading", err0);

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* tests/core_golden.txt */
// rom image: 256 bytes in hex, 16 per line, line n holds addresses n*16 to n*16+15
// then one checked pixel per line: h v red green blue, all hex
a5 a4 a7 a6 a1 a0 a3 a2 ad ac af ae a9 a8 ab aa
b5 b4 b7 b6 b1 b0 b3 b2 bd bc bf be b9 b8 bb ba
85 84 87 86 81 80 83 82 8d 8c 8f 8e 89 88 8b 8a
95 94 97 96 91 90 93 92 9d 9c 9f 9e 99 98 9b 9a
e5 e4 e7 e6 e1 e0 e3 e2 ed ec ef ee e9 e8 eb ea
f5 f4 f7 f6 f1 f0 f3 f2 fd fc ff fe f9 f8 fb fa
c5 c4 c7 c6 c1 c0 c3 c2 cd cc cf ce c9 c8 cb ca
d5 d4 d7 d6 d1 d0 d3 d2 dd dc df de d9 d8 db da
25 24 27 26 21 20 23 22 2d 2c 2f 2e 29 28 2b 2a
35 34 37 36 31 30 33 32 3d 3c 3f 3e 39 38 3b 3a
05 04 07 06 01 00 03 02 0d 0c 0f 0e 09 08 0b 0a
15 14 17 16 11 10 13 12 1d 1c 1f 1e 19 18 1b 1a
65 64 67 66 61 60 63 62 6d 6c 6f 6e 69 68 6b 6a
75 74 77 76 71 70 73 72 7d 7c 7f 7e 79 78 7b 7a
45 44 47 46 41 40 43 42 4d 4c 4f 4e 49 48 4b 4a
55 54 57 56 51 50 53 52 5d 5c 5f 5e 59 58 5b 5a
00 00 a 5 f
05 03 9 0 9
11 02 8 4 c
1f 17 d a 7
0c 14 e 9 7
09 0f 5 c 9

/* filelist.f */
src/core_pkg.sv
src/spi_byte_rx.sv
src/ioctl_loader.sv
src/vid_timing.sv
src/tile_render.sv
src/core_top.sv
tests/core_test.sv

/* run_sim.sh */
#!/bin/sh
# build and run the core testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module core_test -f filelist.f -o core_sim \
    && ./obj_dir/core_sim > sim.log 2>&1 \
    || { echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Something failed" sim.log && { echo "simulation FAILED"; exit 1; }
echo "simulation passed"
